//--- hdl/tx_bit_pkg.sv
// shared widths and descriptor layout; length must stay within the 1024-word buffer
package tx_bit_pkg;

    // queue count fixed by the 2-bit queue index
    localparam int NUM_QUEUES = 4;

    // host descriptor and stream word sizes
    localparam int DESC_W   = 32;
    localparam int STREAM_W = 64;

    // packet buffer depth is 2**BUF_ADDR_W words
    localparam int BUF_ADDR_W = 10;

    // frame length in stream words
    localparam int LEN_W   = 13;
    localparam int LEN_LSB = 0;

    // ack request flag
    localparam int NEED_ACK_BIT = 13;

    // retransmission limit
    localparam int RETRY_LSB = 14;
    localparam int RETRY_W   = 4;

    // bits 19:18 are reserved in the descriptor

    // sequence number, reported back on try-complete
    localparam int SN_LSB = 20;
    localparam int SN_W   = 10;

    // linux priority, in the top two bits
    localparam int PRIO_LSB = 30;
    localparam int PRIO_W   = 2;

    // start strobe width toward the phy
    localparam int START_PULSE_CYCLES = 6;

endpackage

//--- hdl/tx_desc_capture.sv
// queue_sel and desc_in are sampled on the clock after dma_done falls; hold them until then
`timescale 1ns/10ps

module tx_desc_capture (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                dma_done,
    input  logic [1:0]                          queue_sel,
    input  logic [tx_bit_pkg::DESC_W-1:0]       desc_in,
    output logic [tx_bit_pkg::NUM_QUEUES-1:0]   queue_push,
    output logic [tx_bit_pkg::DESC_W-1:0]       desc_word
);

    logic dma_done_d;
    logic dma_fall;

    // dma finished once the strobe goes low again
    assign dma_fall = dma_done_d & ~dma_done;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            dma_done_d <= 1'b0;
            queue_push <= '0;
        end else begin
            dma_done_d <= dma_done;
            queue_push <= '0;
            // one-hot push toward the selected queue
            if (dma_fall) begin
                queue_push[queue_sel] <= 1'b1;
            end
        end
    end

    // descriptor travels next to its push bit
    always_ff @(posedge clk) begin
        if (dma_fall) begin
            desc_word <= desc_in;
        end
    end

endmodule

//--- hdl/tx_desc_queue.sv
// QUEUE_DEPTH must be a power of two; push when full and pop when empty are dropped silently
`timescale 1ns/10ps

module tx_desc_queue #(
    parameter int QUEUE_DEPTH = 64
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            push,
    input  logic [tx_bit_pkg::DESC_W-1:0]   push_data,
    input  logic                            pop,
    output logic [tx_bit_pkg::DESC_W-1:0]   rd_data,
    output logic                            empty,
    output logic                            full,
    output logic [$clog2(QUEUE_DEPTH):0]    count
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    logic [tx_bit_pkg::DESC_W-1:0] mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]              wr_ptr;
    logic [PTR_W-1:0]              rd_ptr;
    logic                          do_push;
    logic                          do_pop;

    // flags straight from the occupancy count
    assign empty = (count == '0);
    assign full  = (count == (PTR_W + 1)'(QUEUE_DEPTH));

    // overflow and underflow requests have no effect
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // storage array
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // registered read, word shows up the cycle after the pop
    always_ff @(posedge clk) begin
        if (do_pop) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // pointers wrap on their own width
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // occupancy, unchanged on simultaneous push and pop
    always_ff @(posedge clk) begin
        if (!rstn) begin
            count <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hdl/tx_sched_fill.sv
// frame length must be 1 to 1024 words; a stalled stream holds fill forever, no timeout here
`timescale 1ns/10ps

module tx_sched_fill (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic [tx_bit_pkg::NUM_QUEUES-1:0]   tx_allowed,
    input  logic [tx_bit_pkg::NUM_QUEUES-1:0]   queue_empty,
    input  logic [tx_bit_pkg::DESC_W-1:0]       queue_rd_data [tx_bit_pkg::NUM_QUEUES],
    input  logic                                tx_busy,
    input  logic                                tx_end,
    input  logic [tx_bit_pkg::STREAM_W-1:0]     stream_data,
    input  logic                                emptyn,
    input  logic                                auto_start_mode,
    input  logic [tx_bit_pkg::BUF_ADDR_W-1:0]   num_dma_symbol_th,
    input  logic                                tx_try_complete,
    output logic [tx_bit_pkg::NUM_QUEUES-1:0]   queue_pop,
    output logic                                ask_data,
    output logic                                wr_en,
    output logic [tx_bit_pkg::BUF_ADDR_W-1:0]   wr_addr,
    output logic [tx_bit_pkg::STREAM_W-1:0]     wr_data,
    output logic                                start,
    output logic [1:0]                          tx_queue_idx,
    output logic                                tx_pkt_need_ack,
    output logic [tx_bit_pkg::RETRY_W-1:0]      tx_pkt_retrans_limit,
    output logic [tx_bit_pkg::SN_W-1:0]         tx_pkt_sn,
    output logic [tx_bit_pkg::PRIO_W-1:0]       linux_prio
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_FETCH = 2'd1;
    localparam logic [1:0] ST_FILL  = 2'd2;

    logic [1:0]                                 state;
    logic [tx_bit_pkg::DESC_W-1:0]              cur_desc;
    logic [tx_bit_pkg::LEN_W-1:0]               cur_len;
    logic [tx_bit_pkg::LEN_W-1:0]               wr_cnt;
    logic [tx_bit_pkg::NUM_QUEUES-1:0]          ready;
    logic                                       grant_valid;
    logic [1:0]                                 grant_idx;
    logic [tx_bit_pkg::NUM_QUEUES-1:0]          grant_onehot;
    logic                                       accept;
    logic                                       th_hit;
    logic [tx_bit_pkg::START_PULSE_CYCLES-1:0]  start_sr;

    // a queue competes only if allowed, non-empty and the phy is free
    assign ready = tx_allowed & ~queue_empty & {tx_bit_pkg::NUM_QUEUES{~tx_busy}};

    // fixed priority, queue 0 wins
    always_comb begin
        grant_valid  = |ready;
        grant_idx    = '0;
        grant_onehot = '0;
        for (int i = tx_bit_pkg::NUM_QUEUES - 1; i >= 0; i--) begin
            if (ready[i]) begin
                grant_idx = 2'(i);
            end
        end
        if (grant_valid) begin
            grant_onehot[grant_idx] = 1'b1;
        end
    end

    // pop in idle so the queue word is valid during fetch
    assign queue_pop = (state == ST_IDLE) ? grant_onehot : '0;

    // descriptor fields of the frame in flight
    assign cur_len              = cur_desc[tx_bit_pkg::LEN_LSB +: tx_bit_pkg::LEN_W];
    assign tx_pkt_need_ack      = cur_desc[tx_bit_pkg::NEED_ACK_BIT];
    assign tx_pkt_retrans_limit = cur_desc[tx_bit_pkg::RETRY_LSB +: tx_bit_pkg::RETRY_W];

    // stream handshake
    assign accept = ask_data & emptyn;

    // threshold seen on the buffer write port
    assign th_hit = wr_en & (wr_addr == num_dma_symbol_th);

    // pulse only leaves in auto-start mode
    assign start = auto_start_mode & (|start_sr);

    // fetch and fill FSM
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= ST_IDLE;
            ask_data     <= 1'b0;
            wr_en        <= 1'b0;
            wr_cnt       <= '0;
            tx_queue_idx <= '0;
            cur_desc     <= '0;
        end else begin
            wr_en <= 1'b0;
            case (state)
                ST_IDLE: begin
                    wr_cnt <= '0;
                    if (grant_valid) begin
                        tx_queue_idx <= grant_idx;
                        state        <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    // popped word arrived this cycle
                    cur_desc <= queue_rd_data[tx_queue_idx];
                    ask_data <= 1'b1;
                    state    <= ST_FILL;
                end
                ST_FILL: begin
                    wr_en <= accept;
                    if (accept) begin
                        wr_cnt <= wr_cnt + 1'b1;
                        // last word of the frame taken
                        if (wr_cnt == cur_len - 1'b1) begin
                            ask_data <= 1'b0;
                        end
                    end
                    // phy done with the buffer
                    if (tx_end) begin
                        ask_data <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // write port, one cycle behind the accepted word
    always_ff @(posedge clk) begin
        wr_addr <= wr_cnt[tx_bit_pkg::BUF_ADDR_W-1:0];
        wr_data <= stream_data;
    end

    // start shift register and try-complete status
    always_ff @(posedge clk) begin
        if (!rstn) begin
            start_sr   <= '0;
            tx_pkt_sn  <= '0;
            linux_prio <= '0;
        end else begin
            start_sr <= {start_sr[tx_bit_pkg::START_PULSE_CYCLES-2:0], th_hit};
            if (tx_try_complete) begin
                tx_pkt_sn  <= cur_desc[tx_bit_pkg::SN_LSB +: tx_bit_pkg::SN_W];
                linux_prio <= cur_desc[tx_bit_pkg::PRIO_LSB +: tx_bit_pkg::PRIO_W];
            end
        end
    end

endmodule

//--- hdl/tx_pkt_buffer.sv
// simple dual-port RAM, no reset; read data undefined until the address is written
`timescale 1ns/10ps

module tx_pkt_buffer (
    input  logic                                clk,
    input  logic                                wr_en,
    input  logic [tx_bit_pkg::BUF_ADDR_W-1:0]   wr_addr,
    input  logic [tx_bit_pkg::STREAM_W-1:0]     wr_data,
    input  logic [tx_bit_pkg::BUF_ADDR_W-1:0]   rd_addr,
    output logic [tx_bit_pkg::STREAM_W-1:0]     rd_data
);

    logic [tx_bit_pkg::STREAM_W-1:0] mem [2**tx_bit_pkg::BUF_ADDR_W];

    // write side, filled by the scheduler
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // phy read, one cycle latency
    always_ff @(posedge clk) begin
        // same-address collision returns the new word
        if (wr_en && (wr_addr == rd_addr)) begin
            rd_data <= wr_data;
        end else begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- hdl/tx_bit_intf.sv
// top level; a descriptor appears in its queue count two clocks after dma_done falls
`timescale 1ns/10ps

module tx_bit_intf #(
    parameter int QUEUE_DEPTH = 64
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                dma_done,
    input  logic [1:0]                          queue_sel,
    input  logic [tx_bit_pkg::DESC_W-1:0]       desc_in,
    input  logic [tx_bit_pkg::NUM_QUEUES-1:0]   tx_allowed,
    input  logic                                tx_busy,
    input  logic                                tx_end,
    input  logic [tx_bit_pkg::STREAM_W-1:0]     stream_data,
    input  logic                                emptyn,
    input  logic                                auto_start_mode,
    input  logic [tx_bit_pkg::BUF_ADDR_W-1:0]   num_dma_symbol_th,
    input  logic                                tx_try_complete,
    input  logic [tx_bit_pkg::BUF_ADDR_W-1:0]   bram_addr,
    output logic                                ask_data,
    output logic                                start,
    output logic [1:0]                          tx_queue_idx,
    output logic                                tx_pkt_need_ack,
    output logic [tx_bit_pkg::RETRY_W-1:0]      tx_pkt_retrans_limit,
    output logic [tx_bit_pkg::SN_W-1:0]         tx_pkt_sn,
    output logic [tx_bit_pkg::PRIO_W-1:0]       linux_prio,
    output logic [tx_bit_pkg::STREAM_W-1:0]     bram_data,
    output logic [$clog2(QUEUE_DEPTH):0]        queue_count [tx_bit_pkg::NUM_QUEUES]
);

    logic [tx_bit_pkg::NUM_QUEUES-1:0]  queue_push;
    logic [tx_bit_pkg::DESC_W-1:0]      desc_word;
    logic [tx_bit_pkg::NUM_QUEUES-1:0]  queue_pop;
    logic [tx_bit_pkg::NUM_QUEUES-1:0]  queue_empty;
    logic [tx_bit_pkg::DESC_W-1:0]      queue_rd_data [tx_bit_pkg::NUM_QUEUES];
    logic                               wr_en;
    logic [tx_bit_pkg::BUF_ADDR_W-1:0]  wr_addr;
    logic [tx_bit_pkg::STREAM_W-1:0]    wr_data;

    // host side, dma-done edge into a queue push
    tx_desc_capture i_capture (
        .clk        (clk),
        .rstn       (rstn),
        .dma_done   (dma_done),
        .queue_sel  (queue_sel),
        .desc_in    (desc_in),
        .queue_push (queue_push),
        .desc_word  (desc_word)
    );

    // one descriptor FIFO per access category
    for (genvar g = 0; g < tx_bit_pkg::NUM_QUEUES; g++) begin : gen_queue
        tx_desc_queue #(
            .QUEUE_DEPTH (QUEUE_DEPTH)
        ) i_queue (
            .clk       (clk),
            .rstn      (rstn),
            .push      (queue_push[g]),
            .push_data (desc_word),
            .pop       (queue_pop[g]),
            .rd_data   (queue_rd_data[g]),
            .empty     (queue_empty[g]),
            // full only blocks pushes inside the queue
            .full      (),
            .count     (queue_count[g])
        );
    end

    // arbitration and buffer fill
    tx_sched_fill i_sched (
        .clk                  (clk),
        .rstn                 (rstn),
        .tx_allowed           (tx_allowed),
        .queue_empty          (queue_empty),
        .queue_rd_data        (queue_rd_data),
        .tx_busy              (tx_busy),
        .tx_end               (tx_end),
        .stream_data          (stream_data),
        .emptyn               (emptyn),
        .auto_start_mode      (auto_start_mode),
        .num_dma_symbol_th    (num_dma_symbol_th),
        .tx_try_complete      (tx_try_complete),
        .queue_pop            (queue_pop),
        .ask_data             (ask_data),
        .wr_en                (wr_en),
        .wr_addr              (wr_addr),
        .wr_data              (wr_data),
        .start                (start),
        .tx_queue_idx         (tx_queue_idx),
        .tx_pkt_need_ack      (tx_pkt_need_ack),
        .tx_pkt_retrans_limit (tx_pkt_retrans_limit),
        .tx_pkt_sn            (tx_pkt_sn),
        .linux_prio           (linux_prio)
    );

    // frame buffer, phy reads on the second port
    tx_pkt_buffer i_buffer (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (bram_addr),
        .rd_data (bram_data)
    );

endmodule

//--- testbench/tx_bit_intf_chk.sv
// bound into every tx_sched_fill; fill state encoding must match the scheduler
`timescale 1ns/10ps

module tx_bit_intf_chk (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic [1:0]                        state,
    input  logic                              ask_data,
    input  logic [tx_bit_pkg::NUM_QUEUES-1:0] queue_pop,
    input  logic                              start,
    input  logic                              auto_start_mode
);

    localparam logic [1:0] ST_FILL = 2'd2;

    // failed assertions so far
    int fail_cnt = 0;

    // stream requests only while filling
    ask_only_in_fill: assert property (
        @(posedge clk) disable iff (!rstn) ask_data |-> (state == ST_FILL)
    ) else begin
        $error("ask_data high outside fill");
        fail_cnt++;
    end

    // never two queues popped at once
    pop_onehot: assert property (
        @(posedge clk) disable iff (!rstn) $onehot0(queue_pop)
    ) else begin
        $error("queue_pop has more than one bit set");
        fail_cnt++;
    end

    // start gated by auto-start mode
    start_needs_auto: assert property (
        @(posedge clk) disable iff (!rstn) start |-> auto_start_mode
    ) else begin
        $error("start high while auto_start_mode is low");
        fail_cnt++;
    end

endmodule

bind tx_sched_fill tx_bit_intf_chk i_chk (
    .clk             (clk),
    .rstn            (rstn),
    .state           (state),
    .ask_data        (ask_data),
    .queue_pop       (queue_pop),
    .start           (start),
    .auto_start_mode (auto_start_mode)
);

//--- testbench/tx_bit_monitor.sv
// records accepted stream words and start pulses; per-test state is cleared by begin_test
`timescale 1ns/10ps

module tx_bit_monitor (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              ask_data,
    input  logic                              emptyn,
    input  logic [tx_bit_pkg::STREAM_W-1:0]   stream_data,
    input  logic                              start
);

    int          err_cnt = 0;
    int          test_errs = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          pulses = 0;
    int          run_len = 0;
    int          last_width = 0;
    logic [63:0] words [$];

    // handshake words and start runs, sampled on the rising edge
    always @(posedge clk) begin
        if (rstn && ask_data && emptyn) begin
            words.push_back(stream_data);
        end
        if (start) begin
            run_len++;
        end else if (run_len > 0) begin
            pulses++;
            last_width = run_len;
            run_len    = 0;
        end
    end

    task automatic begin_test();
        words.delete();
        pulses     = 0;
        last_width = 0;
        test_errs  = 0;
    endtask

    task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            err_cnt++;
            test_errs++;
        end
    endtask

    task automatic note_failure(string msg);
        $display("Error: %s", msg);
        err_cnt++;
        test_errs++;
    endtask

    task automatic check_length(int len);
        check_val("accepted_words", 64'(words.size()), 64'(len));
    endtask

    task automatic check_word(int addr, logic [63:0] got);
        if (addr >= words.size()) begin
            note_failure("buffer read past the accepted stream words");
        end else begin
            check_val("bram_data", got, words[addr]);
        end
    endtask

    // one pulse of the full width, or none
    task automatic check_start(int exp_pulses);
        check_val("start_pulses", 64'(pulses), 64'(exp_pulses));
        if (exp_pulses > 0) begin
            check_val("start_width", 64'(last_width), 64'(tx_bit_pkg::START_PULSE_CYCLES));
        end
    endtask

    task automatic end_test(int id, string what);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d %s: ok", id, what);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", id, what, test_errs);
        end
    endtask

    task automatic print_totals();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, err_cnt);
    endtask

endmodule

//--- testbench/tb_tx_bit_intf.sv
// one clock domain; each table row must allow a loaded queue and keep its threshold below the length
`timescale 1ns/10ps

module tb_tx_bit_intf;

    localparam int QUEUE_DEPTH = 64;
    localparam int NUM_ROWS    = 6;
    localparam int WAIT_LIMIT  = 4000;
    localparam int PUSH_LIMIT  = 10;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    typedef struct packed {
        logic [1:0]  q;
        logic [12:0] len;
        logic        ack;
        logic [3:0]  retry;
        logic [9:0]  sn;
        logic [1:0]  prio;
        logic [3:0]  allow;
        logic [9:0]  th;
        logic        auto_start;
    } row_t;

    logic                                clk;
    logic                                rstn;
    logic                                dma_done;
    logic [1:0]                          queue_sel;
    logic [tx_bit_pkg::DESC_W-1:0]       desc_in;
    logic [tx_bit_pkg::NUM_QUEUES-1:0]   tx_allowed;
    logic                                tx_busy;
    logic                                tx_end;
    logic [tx_bit_pkg::STREAM_W-1:0]     stream_data;
    logic                                emptyn;
    logic                                auto_start_mode;
    logic [tx_bit_pkg::BUF_ADDR_W-1:0]   num_dma_symbol_th;
    logic                                tx_try_complete;
    logic [tx_bit_pkg::BUF_ADDR_W-1:0]   bram_addr;
    logic                                ask_data;
    logic                                start;
    logic [1:0]                          tx_queue_idx;
    logic                                tx_pkt_need_ack;
    logic [tx_bit_pkg::RETRY_W-1:0]      tx_pkt_retrans_limit;
    logic [tx_bit_pkg::SN_W-1:0]         tx_pkt_sn;
    logic [tx_bit_pkg::PRIO_W-1:0]       linux_prio;
    logic [tx_bit_pkg::STREAM_W-1:0]     bram_data;
    logic [$clog2(QUEUE_DEPTH):0]        queue_count [tx_bit_pkg::NUM_QUEUES];

    row_t        tbl [NUM_ROWS];
    bit          served [NUM_ROWS];
    int          pending [tx_bit_pkg::NUM_QUEUES];
    logic [31:0] lfsr;
    logic        acc_seen;
    logic        word_valid;

    tx_bit_intf #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_dut (
        .clk                  (clk),
        .rstn                 (rstn),
        .dma_done             (dma_done),
        .queue_sel            (queue_sel),
        .desc_in              (desc_in),
        .tx_allowed           (tx_allowed),
        .tx_busy              (tx_busy),
        .tx_end               (tx_end),
        .stream_data          (stream_data),
        .emptyn               (emptyn),
        .auto_start_mode      (auto_start_mode),
        .num_dma_symbol_th    (num_dma_symbol_th),
        .tx_try_complete      (tx_try_complete),
        .bram_addr            (bram_addr),
        .ask_data             (ask_data),
        .start                (start),
        .tx_queue_idx         (tx_queue_idx),
        .tx_pkt_need_ack      (tx_pkt_need_ack),
        .tx_pkt_retrans_limit (tx_pkt_retrans_limit),
        .tx_pkt_sn            (tx_pkt_sn),
        .linux_prio           (linux_prio),
        .bram_data            (bram_data),
        .queue_count          (queue_count)
    );

    tx_bit_monitor i_mon (
        .clk         (clk),
        .rstn        (rstn),
        .ask_data    (ask_data),
        .emptyn      (emptyn),
        .stream_data (stream_data),
        .start       (start)
    );

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    // galois lfsr, one step per bit taken
    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ LFSR_TAPS;
            end
            r = {r[62:0], b};
        end
        return r;
    endfunction

    // descriptor layout: prio, sn, reserved, retry, ack, length
    function automatic logic [31:0] build_desc(row_t row);
        return {row.prio, row.sn, 2'b00, row.retry, row.ack, row.len};
    endfunction

    // lowest allowed queue that still holds a descriptor
    function automatic int pick_queue(logic [3:0] mask);
        int idx;
        idx = -1;
        for (int i = tx_bit_pkg::NUM_QUEUES - 1; i >= 0; i--) begin
            if (mask[i] && pending[i] > 0) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // oldest unserved row pushed into queue q
    function automatic int head_row(int q);
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (!served[r] && int'(tbl[r].q) == q) begin
                return r;
            end
        end
        return -1;
    endfunction

    // queue, len, ack, retry, sn, prio, allowed mask, threshold, auto start
    task automatic load_table();
        tbl[0] = '{2'd2, 13'd12, 1'b1, 4'd3, 10'd101, 2'd1, 4'b1100, 10'd3, 1'b1};
        tbl[1] = '{2'd0, 13'd9,  1'b0, 4'd7, 10'd517, 2'd3, 4'b1010, 10'd0, 1'b1};
        tbl[2] = '{2'd3, 13'd20, 1'b1, 4'd15, 10'd1023, 2'd0, 4'b1111, 10'd7, 1'b0};
        tbl[3] = '{2'd1, 13'd8,  1'b0, 4'd1, 10'd64, 2'd2, 4'b1000, 10'd5, 1'b1};
        tbl[4] = '{2'd0, 13'd16, 1'b1, 4'd9, 10'd300, 2'd1, 4'b0110, 10'd2, 1'b0};
        tbl[5] = '{2'd2, 13'd10, 1'b0, 4'd4, 10'd777, 2'd3, 4'b0001, 10'd4, 1'b1};
    endtask

    task automatic abort_run(string msg);
        i_mon.note_failure(msg);
        i_mon.print_totals();
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic wait_ask(logic level, string what);
        int n;
        n = 0;
        while (ask_data != level) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run({"timed out waiting for ", what});
            end
        end
    endtask

    // dma_done pulse, then wait for the count to move
    task automatic push_desc(int r);
        int n;
        int q;
        q = int'(tbl[r].q);
        @(negedge clk);
        queue_sel = tbl[r].q;
        desc_in   = build_desc(tbl[r]);
        dma_done  = 1'b1;
        @(negedge clk);
        dma_done = 1'b0;
        pending[q]++;
        n = 0;
        while (int'(queue_count[q]) != pending[q]) begin
            @(negedge clk);
            n++;
            if (n > PUSH_LIMIT) begin
                abort_run("queue count never reached the number of pushes");
            end
        end
        for (int i = 0; i < tx_bit_pkg::NUM_QUEUES; i++) begin
            i_mon.check_val("queue_count", 64'(queue_count[i]), 64'(pending[i]));
        end
    endtask

    task automatic run_frame(int it);
        int q;
        int r;
        q = pick_queue(tbl[it].allow);
        if (q < 0) begin
            abort_run("table row allows no loaded queue");
        end
        r = head_row(q);
        i_mon.begin_test();
        @(negedge clk);
        auto_start_mode   = tbl[it].auto_start;
        num_dma_symbol_th = tbl[it].th;
        tx_allowed        = tbl[it].allow;
        wait_ask(1'b1, "ask_data to rise");
        // one pop per frame
        tx_allowed = '0;
        served[r]  = 1'b1;
        pending[q]--;
        i_mon.check_val("tx_queue_idx", 64'(tx_queue_idx), 64'(q));
        i_mon.check_val("tx_pkt_need_ack", 64'(tx_pkt_need_ack), 64'(tbl[r].ack));
        i_mon.check_val("tx_pkt_retrans_limit", 64'(tx_pkt_retrans_limit), 64'(tbl[r].retry));
        wait_ask(1'b0, "ask_data to drop");
        i_mon.check_val("queue_count", 64'(queue_count[q]), 64'(pending[q]));
        i_mon.check_length(int'(tbl[r].len));
        // phy side read back, data one cycle after the address
        for (int a = 0; a < int'(tbl[r].len); a++) begin
            bram_addr = 10'(a);
            @(negedge clk);
            i_mon.check_word(a, bram_data);
        end
        i_mon.check_start(tbl[it].auto_start ? 1 : 0);
        tx_try_complete = 1'b1;
        @(negedge clk);
        tx_try_complete = 1'b0;
        i_mon.check_val("tx_pkt_sn", 64'(tx_pkt_sn), 64'(tbl[r].sn));
        i_mon.check_val("linux_prio", 64'(linux_prio), 64'(tbl[r].prio));
        tx_end = 1'b1;
        @(negedge clk);
        tx_end = 1'b0;
        i_mon.end_test(it + 1, "frame");
    endtask

    // stream source, new word only after the current one was taken
    always @(posedge clk) begin
        acc_seen <= ask_data & emptyn;
    end

    always @(negedge clk) begin
        if (!rstn) begin
            emptyn     = 1'b0;
            word_valid = 1'b0;
        end else begin
            if (acc_seen || !word_valid) begin
                stream_data = rand_bits(64);
                word_valid  = 1'b1;
            end
            // roughly one gap in four
            emptyn = (rand_bits(2) != 64'd0);
        end
    end

    initial begin
        lfsr              = 32'h6de5;
        acc_seen          = 1'b0;
        word_valid        = 1'b0;
        rstn              = 1'b0;
        dma_done          = 1'b0;
        queue_sel         = '0;
        desc_in           = '0;
        tx_allowed        = '0;
        tx_busy           = 1'b0;
        tx_end            = 1'b0;
        stream_data       = '0;
        emptyn            = 1'b0;
        auto_start_mode   = 1'b0;
        num_dma_symbol_th = '0;
        tx_try_complete   = 1'b0;
        bram_addr         = '0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            served[i] = 1'b0;
        end
        for (int i = 0; i < tx_bit_pkg::NUM_QUEUES; i++) begin
            pending[i] = 0;
        end
        load_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        // fill the queues with nothing allowed
        i_mon.begin_test();
        for (int r = 0; r < NUM_ROWS; r++) begin
            push_desc(r);
        end
        i_mon.end_test(0, "queue counts");
        for (int it = 0; it < NUM_ROWS; it++) begin
            run_frame(it);
        end
        if (i_dut.i_sched.i_chk.fail_cnt != 0) begin
            i_mon.note_failure("scheduler assertions failed during the run");
        end
        i_mon.print_totals();
        if (i_mon.err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- tx_bit_intf.f
hdl/tx_bit_pkg.sv
hdl/tx_desc_capture.sv
hdl/tx_desc_queue.sv
hdl/tx_sched_fill.sv
hdl/tx_pkt_buffer.sv
hdl/tx_bit_intf.sv
testbench/tx_bit_intf_chk.sv
testbench/tx_bit_monitor.sv
testbench/tb_tx_bit_intf.sv

//--- Makefile
TOP = tb_tx_bit_intf

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): tx_bit_intf.f
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tx_bit_intf.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

lint:
	verilator --lint-only --timing --top-module $(TOP) -f tx_bit_intf.f

clean:
	rm -rf obj_dir
